/* build.f */
hdl/isaPkg.sv
hdl/decodePkg.sv
hdl/templateUnits.sv
hdl/slotCounter.sv
hdl/bundleSequencer.sv
hdl/instrDecoder.sv
hdl/decodeTop.sv
tests/tbClock.sv
tests/tbDecode.sv

/* hdl/bundleSequencer.sv */
// ==========================================================
// bundle sequencing FSM
// accepts a bundle, then steps its slots while not stalled
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module bundleSequencer (
	input  logic clk,
	input  logic rst,
	input  logic bundleValid,
	input  logic stall,
	input  logic last,
	output logic loadBundle,
	output logic clearCount,
	output logic stepSlot,
	output logic loadOut,
	output logic busy
);
	typedef enum logic {
		IDLE,
		DECODE
	} state_t;

	state_t state;
	state_t stateNext;

	// strobes for the datapath
	assign loadBundle = (state == IDLE) && bundleValid;
	assign clearCount = loadBundle;
	assign loadOut    = (state == DECODE) && !stall;
	assign stepSlot   = loadOut && !last;
	assign busy       = (state == DECODE);

	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
				if (bundleValid)
					stateNext = DECODE;
			DECODE:
				// final slot leaves on this edge
				if (!stall && last)
					stateNext = IDLE;
			default:
				stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= stateNext;
	end

endmodule

`default_nettype wire

/* hdl/decodePkg.sv */
// ==========================================================
// decode stage transport types
// the per-slot decode bus and the fetched bundle
// ==========================================================
`default_nettype none

package decodePkg;

	typedef struct packed {
		isaPkg::unit_t    unit;
		logic             rfw;
		logic [5:0]       rd;
		logic [5:0]       rs1;
		logic             hasConst;
		logic [63:0]      constant;
		isaPkg::memSize_t memSize;
		// memory class flags
		logic             load;
		logic             store;
		logic             mem;
		logic             memNdx;
		logic             rmw;
		logic             push;
		logic             tlb;
		// flow control
		logic             branch;
		logic             jump;
		logic             jal;
		logic             ret;
		logic             brk;
		logic             rti;
		logic             sync;
		logic             canEx;
		logic             oddball;
	} decodeBus_t;

	// template sits in the low byte, slot0 just above it
	typedef struct packed {
		isaPkg::instr_u                  slot2;
		isaPkg::instr_u                  slot1;
		isaPkg::instr_u                  slot0;
		logic [isaPkg::TEMPLATE_W-1:0]   template;
	} bundle_t;

endpackage

`default_nettype wire

/* hdl/decodeTop.sv */
// ==========================================================
// decode stage top level
// bundle register, slot mux and registered decode output
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module decodeTop #(
	parameter int SLOTS = 3
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       bundleValid,
	input  decodePkg::bundle_t         bundleIn,
	input  logic                       stall,
	output logic                       busy,
	output logic                       decValid,
	output logic [$clog2(SLOTS)-1:0]   decSlot,
	output decodePkg::decodeBus_t      decBus,
	output logic                       badTemplate
);
	import isaPkg::*;
	import decodePkg::*;

	localparam int SLOT_W = $clog2(SLOTS);

	bundle_t           bundleReg;
	unit_t             unit0;
	unit_t             unit1;
	unit_t             unit2;
	unit_t             curUnit;
	instr_u            curInstr;
	decodeBus_t        decNext;
	logic              reserved;
	logic [SLOT_W-1:0] slot;
	logic              last;
	logic              loadBundle;
	logic              clearCount;
	logic              stepSlot;
	logic              loadOut;

	always_ff @(posedge clk)
	begin
		if (loadBundle)
			bundleReg <= bundleIn;
	end

	templateUnits u_templateUnits (
		.template (bundleReg.template),
		.unit0    (unit0),
		.unit1    (unit1),
		.unit2    (unit2),
		.reserved (reserved)
	);

	slotCounter #(
		.SLOTS (SLOTS)
	) u_slotCounter (
		.clk    (clk),
		.rst    (rst),
		.clear  (clearCount),
		.enable (stepSlot),
		.slot   (slot),
		.last   (last)
	);

	bundleSequencer u_bundleSequencer (
		.clk         (clk),
		.rst         (rst),
		.bundleValid (bundleValid),
		.stall       (stall),
		.last        (last),
		.loadBundle  (loadBundle),
		.clearCount  (clearCount),
		.stepSlot    (stepSlot),
		.loadOut     (loadOut),
		.busy        (busy)
	);

	// pick the current slot and its unit
	always_comb
	begin
		if (slot == SLOT_W'(0))
		begin
			curInstr = bundleReg.slot0;
			curUnit  = unit0;
		end
		else if (slot == SLOT_W'(1))
		begin
			curInstr = bundleReg.slot1;
			curUnit  = unit1;
		end
		else
		begin
			curInstr = bundleReg.slot2;
			curUnit  = unit2;
		end
	end

	instrDecoder u_instrDecoder (
		.unit   (curUnit),
		.instr  (curInstr),
		.decBus (decNext)
	);

	// output holds its value across stalled edges
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decValid    <= 1'b0;
			decSlot     <= '0;
			decBus      <= '0;
			badTemplate <= 1'b0;
		end
		else
		begin
			decValid <= loadOut;
			if (loadOut)
			begin
				decSlot     <= slot;
				decBus      <= decNext;
				badTemplate <= reserved;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
// ==========================================================
// single slot instruction decoder
// register write, constant, memory size and flow flags
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  isaPkg::unit_t         unit,
	input  isaPkg::instr_u        instr,
	output decodePkg::decodeBus_t decBus
);
	import isaPkg::*;

	logic [3:0] op;
	logic [4:0] fn;
	logic       isBr;
	logic       isSt;
	logic       isChki;
	logic       isPush;
	logic       isPushc;
	logic       isCas;
	logic       isCache;
	logic       isRti;
	logic       isSei;
	logic       isRex;
	logic       isBrk;
	logic [5:0] rdSel;
	logic       constSel;
	logic       canExSel;
	memSize_t   sizeSel;

	// size table shared by direct and indexed forms
	function automatic memSize_t sizeOf(input unit_t u, input logic [3:0] code);
		memSize_t sz;
		sz = SZ_DECI;
		if (u == UNIT_LOAD)
			case (code)
				LD_LDB, LD_LDBU:  sz = SZ_BYTE;
				LD_LDC, LD_LDCU:  sz = SZ_WYDE;
				LD_LDT, LD_LDTU:  sz = SZ_TETRA;
				LD_LDP, LD_LDPU:  sz = SZ_PENTA;
				LD_LDO, LD_LDOU:  sz = SZ_OCTA;
				default:          sz = SZ_DECI;
			endcase
		else if (u == UNIT_STORE)
			case (code)
				ST_STB:  sz = SZ_BYTE;
				ST_STC:  sz = SZ_WYDE;
				ST_STT:  sz = SZ_TETRA;
				ST_STP:  sz = SZ_PENTA;
				ST_STO:  sz = SZ_OCTA;
				default: sz = SZ_DECI;
			endcase
		return sz;
	endfunction

	assign op      = instr.iForm.opcode;
	assign fn      = instr.rForm.funct5;
	assign isBr    = (unit == UNIT_BRANCH);
	assign isSt    = (unit == UNIT_STORE);
	assign isChki  = isBr && (op == BR_CHKI);
	assign isPushc = isSt && (op == ST_PUSHC);
	assign isPush  = isSt && (op == ST_PUSH || op == ST_PUSHC);
	assign isCas   = isSt && (op == ST_CAS || (op == ST_MSX && fn == FN_CAS));
	assign isCache = isSt && (op == ST_CACHE || (op == ST_MSX && fn == FN_CACHE));
	assign isRti   = isBr && (op == BR_RTI) && (fn == FN_RTI);
	assign isSei   = isBr && (op == BR_RTI) && (fn == FN_SEI);
	assign isRex   = isBr && (op == BR_RTI) && (fn == FN_REX);
	assign isBrk   = isBr && (op == BR_BRK);

	// destination select and immediate presence per unit
	always_comb
	begin
		rdSel    = 6'd0;
		constSel = 1'b0;
		sizeSel  = SZ_DECI;
		canExSel = 1'b0;
		case (unit)
			UNIT_BRANCH:
			begin
				if (op == BR_JAL || op == BR_RET || isSei)
					rdSel = instr.iForm.rd;
				constSel = (op == BR_CHKI || op == BR_JAL);
				canExSel = (op == BR_BRK || op == BR_CHK || op == BR_CHKI);
			end
			UNIT_INT:
			begin
				rdSel    = instr.iForm.rd;
				constSel = (op != INT_R3);
				canExSel = (op == INT_MULI || op == INT_DIVI || op == INT_MODI)
					|| (op == INT_R3 && (fn == FN_MUL || fn == FN_DIV || fn == FN_MOD));
			end
			UNIT_FLT:
			begin
				rdSel    = instr.iForm.rd;
				canExSel = (op == FLT_FLT2)
					&& (fn == FN_FADD || fn == FN_FSUB || fn == FN_FMUL || fn == FN_FDIV);
			end
			UNIT_LOAD:
			begin
				rdSel    = instr.iForm.rd;
				constSel = (op != LD_MLX);
				sizeSel  = sizeOf(unit, (op == LD_MLX) ? fn[3:0] : op);
				// any load may fault
				canExSel = 1'b1;
			end
			UNIT_STORE:
			begin
				if (isPush || op == ST_TLB || isCas)
					rdSel = instr.iForm.rd;
				constSel = !(op == ST_MSX || op == ST_PUSH || op == ST_TLB);
				sizeSel  = sizeOf(unit, (op == ST_MSX) ? fn[3:0] : op);
			end
			default:
				rdSel = 6'd0;
		endcase
	end

	always_comb
	begin
		decBus          = '0;
		decBus.unit     = unit;
		decBus.rd       = rdSel;
		decBus.rfw      = (rdSel != 6'd0);
		decBus.rs1      = instr.iForm.rs1;
		decBus.hasConst = constSel;
		// stores and CHKI split the constant around rs2 and rd
		if ((isSt || isChki) && !isPushc)
			decBus.constant = {{42{instr.iForm.immHi[6]}}, instr.iForm.immHi,
				instr.iForm.immLo[14:6], instr.iForm.rd};
		else
			decBus.constant = {{42{instr.iForm.immHi[6]}}, instr.iForm.immHi,
				instr.iForm.immLo};
		decBus.memSize  = sizeSel;
		decBus.load     = (unit == UNIT_LOAD);
		decBus.store    = isSt;
		decBus.mem      = (unit == UNIT_LOAD) || isSt;
		decBus.memNdx   = ((unit == UNIT_LOAD) && op == LD_MLX) || (isSt && op == ST_MSX);
		decBus.rmw      = isCas;
		decBus.push     = isPush;
		decBus.tlb      = isSt && (op == ST_TLB);
		decBus.branch   = isBr && (op == BR_BCC || op == BR_BBC || op == BR_BEQI
			|| op == BR_BNEI || op == BR_BLTI);
		decBus.jump     = isBr && (op == BR_JMP);
		decBus.jal      = isBr && (op == BR_JAL);
		decBus.ret      = isBr && (op == BR_RET);
		decBus.brk      = isBrk;
		decBus.rti      = isRti;
		decBus.sync     = (isBr && op == BR_RTI && fn == FN_SYNC) || isRti || isBrk;
		decBus.canEx    = canExSel;
		decBus.oddball  = isRti || isSei || isRex || isCache || (unit == UNIT_FLT);
	end

endmodule

`default_nettype wire

/* hdl/isaPkg.sv */
// ==========================================================
// instruction set definitions for the bundle decoder
// unit codes, opcodes, function codes, access sizes and
// the two-format instruction word
// ==========================================================
`default_nettype none

package isaPkg;

	localparam int TEMPLATE_W = 8;

	typedef enum logic [2:0] {
		UNIT_NONE   = 3'd0,
		UNIT_BRANCH = 3'd1,
		UNIT_INT    = 3'd2,
		UNIT_FLT    = 3'd3,
		UNIT_LOAD   = 3'd4,
		UNIT_STORE  = 3'd5
	} unit_t;

	typedef enum logic [2:0] {
		SZ_BYTE  = 3'd0,
		SZ_WYDE  = 3'd1,
		SZ_TETRA = 3'd2,
		SZ_PENTA = 3'd3,
		SZ_OCTA  = 3'd4,
		SZ_DECI  = 3'd5
	} memSize_t;

	// ==========================================================
	// branch unit opcodes
	// ==========================================================
	localparam logic [3:0] BR_BCC  = 4'h0;
	localparam logic [3:0] BR_BBC  = 4'h1;
	// register-target branch, not predictable
	localparam logic [3:0] BR_BRCC = 4'h2;
	localparam logic [3:0] BR_JMP  = 4'h3;
	localparam logic [3:0] BR_BEQI = 4'h4;
	localparam logic [3:0] BR_JAL  = 4'h5;
	localparam logic [3:0] BR_BNEI = 4'h6;
	localparam logic [3:0] BR_BLTI = 4'h7;
	localparam logic [3:0] BR_RET  = 4'h8;
	localparam logic [3:0] BR_RTI  = 4'h9;
	localparam logic [3:0] BR_BRK  = 4'hA;
	localparam logic [3:0] BR_CHK  = 4'hB;
	localparam logic [3:0] BR_CHKI = 4'hC;

	// variants carried in funct5 of the RTI opcode
	localparam logic [4:0] FN_RTI  = 5'h00;
	localparam logic [4:0] FN_SEI  = 5'h01;
	localparam logic [4:0] FN_WAIT = 5'h02;
	localparam logic [4:0] FN_SYNC = 5'h03;
	localparam logic [4:0] FN_REX  = 5'h04;

	// integer unit
	localparam logic [3:0] INT_ADDI = 4'h0;
	localparam logic [3:0] INT_ANDI = 4'h1;
	localparam logic [3:0] INT_R3   = 4'h2;
	localparam logic [3:0] INT_ORI  = 4'h3;
	localparam logic [3:0] INT_MULI = 4'h4;
	localparam logic [3:0] INT_DIVI = 4'h5;
	localparam logic [3:0] INT_MODI = 4'h6;
	localparam logic [3:0] INT_XORI = 4'h7;
	localparam logic [4:0] FN_MUL   = 5'h08;
	localparam logic [4:0] FN_DIV   = 5'h09;
	localparam logic [4:0] FN_MOD   = 5'h0A;

	// float unit, arithmetic selected by funct5
	localparam logic [3:0] FLT_FLT2 = 4'h2;
	localparam logic [4:0] FN_FADD  = 5'h04;
	localparam logic [4:0] FN_FSUB  = 5'h05;
	localparam logic [4:0] FN_FMUL  = 5'h08;
	localparam logic [4:0] FN_FDIV  = 5'h09;

	// ==========================================================
	// memory opcodes, indexed forms repeat them in funct5
	// ==========================================================
	localparam logic [3:0] LD_LDB  = 4'h0;
	localparam logic [3:0] LD_LDC  = 4'h1;
	localparam logic [3:0] LD_LDP  = 4'h2;
	localparam logic [3:0] LD_LDD  = 4'h3;
	localparam logic [3:0] LD_LDBU = 4'h4;
	localparam logic [3:0] LD_LDCU = 4'h5;
	localparam logic [3:0] LD_LDPU = 4'h6;
	localparam logic [3:0] LD_LDDR = 4'h7;
	localparam logic [3:0] LD_LDT  = 4'h8;
	localparam logic [3:0] LD_LDO  = 4'h9;
	localparam logic [3:0] LD_LDTU = 4'hA;
	localparam logic [3:0] LD_LDOU = 4'hB;
	localparam logic [3:0] LD_LEA  = 4'hC;
	localparam logic [3:0] LD_MLX  = 4'hF;

	localparam logic [3:0] ST_STB   = 4'h0;
	localparam logic [3:0] ST_STC   = 4'h1;
	localparam logic [3:0] ST_STP   = 4'h2;
	localparam logic [3:0] ST_STD   = 4'h3;
	localparam logic [3:0] ST_STT   = 4'h4;
	localparam logic [3:0] ST_STO   = 4'h5;
	localparam logic [3:0] ST_STDC  = 4'h6;
	localparam logic [3:0] ST_PUSH  = 4'h7;
	localparam logic [3:0] ST_PUSHC = 4'h8;
	localparam logic [3:0] ST_TLB   = 4'h9;
	localparam logic [3:0] ST_CAS   = 4'hA;
	localparam logic [3:0] ST_CACHE = 4'hB;
	localparam logic [3:0] ST_MSX   = 4'hF;
	localparam logic [4:0] FN_CAS   = 5'h0A;
	localparam logic [4:0] FN_CACHE = 5'h0B;

	// register-register and indexed layout
	typedef struct packed {
		logic [4:0] funct5;
		logic [5:0] rs2;
		logic [2:0] size;
		logic [1:0] aqrl;
		logic [7:0] spare;
		logic [5:0] rs1;
		logic [3:0] opcode;
		logic [5:0] rd;
	} rForm_t;

	// immediate layout, immHi holds the sign bit
	typedef struct packed {
		logic [6:0]  immHi;
		logic [1:0]  aqrl;
		logic [14:0] immLo;
		logic [5:0]  rs1;
		logic [3:0]  opcode;
		logic [5:0]  rd;
	} iForm_t;

	typedef union packed {
		rForm_t rForm;
		iForm_t iForm;
	} instr_u;

endpackage

`default_nettype wire

/* hdl/slotCounter.sv */
// ==========================================================
// slot index counter with last-slot flag
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module slotCounter #(
	parameter int SLOTS = 3
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clear,
	input  logic                       enable,
	output logic [$clog2(SLOTS)-1:0]   slot,
	output logic                       last
);
	localparam int SLOT_W = $clog2(SLOTS);

	assign last = (slot == SLOT_W'(SLOTS - 1));

	always_ff @(posedge clk)
	begin
		if (rst || clear)
			slot <= '0;
		else if (enable)
			// wrap keeps the index inside the bundle
			slot <= last ? '0 : slot + 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/templateUnits.sv */
// ==========================================================
// bundle template to slot unit mapping
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module templateUnits (
	input  logic [isaPkg::TEMPLATE_W-1:0] template,
	output isaPkg::unit_t                 unit0,
	output isaPkg::unit_t                 unit1,
	output isaPkg::unit_t                 unit2,
	output logic                          reserved
);
	import isaPkg::*;

	// slot0 in the top three bits
	logic [8:0] pattern;

	always_comb
	begin
		reserved = 1'b0;
		case (template)
			8'd0:  pattern = {UNIT_INT,    UNIT_INT,    UNIT_INT};
			8'd1:  pattern = {UNIT_INT,    UNIT_INT,    UNIT_BRANCH};
			8'd2:  pattern = {UNIT_LOAD,   UNIT_INT,    UNIT_INT};
			8'd3:  pattern = {UNIT_LOAD,   UNIT_INT,    UNIT_BRANCH};
			8'd4:  pattern = {UNIT_STORE,  UNIT_INT,    UNIT_INT};
			8'd5:  pattern = {UNIT_STORE,  UNIT_INT,    UNIT_BRANCH};
			8'd6:  pattern = {UNIT_LOAD,   UNIT_LOAD,   UNIT_INT};
			8'd7:  pattern = {UNIT_LOAD,   UNIT_LOAD,   UNIT_BRANCH};
			8'd8:  pattern = {UNIT_STORE,  UNIT_STORE,  UNIT_INT};
			8'd9:  pattern = {UNIT_STORE,  UNIT_STORE,  UNIT_BRANCH};
			8'd10: pattern = {UNIT_LOAD,   UNIT_STORE,  UNIT_INT};
			8'd11: pattern = {UNIT_LOAD,   UNIT_STORE,  UNIT_BRANCH};
			8'd12: pattern = {UNIT_INT,    UNIT_FLT,    UNIT_INT};
			8'd13: pattern = {UNIT_INT,    UNIT_FLT,    UNIT_BRANCH};
			8'd14: pattern = {UNIT_LOAD,   UNIT_FLT,    UNIT_INT};
			8'd15: pattern = {UNIT_LOAD,   UNIT_FLT,    UNIT_BRANCH};
			8'd16: pattern = {UNIT_STORE,  UNIT_FLT,    UNIT_INT};
			8'd17: pattern = {UNIT_STORE,  UNIT_FLT,    UNIT_BRANCH};
			8'd18: pattern = {UNIT_BRANCH, UNIT_BRANCH, UNIT_BRANCH};
			8'd19: pattern = {UNIT_LOAD,   UNIT_LOAD,   UNIT_LOAD};
			8'd20: pattern = {UNIT_STORE,  UNIT_STORE,  UNIT_STORE};
			8'd21: pattern = {UNIT_FLT,    UNIT_FLT,    UNIT_FLT};
			8'd22: pattern = {UNIT_INT,    UNIT_INT,    UNIT_FLT};
			8'd23: pattern = {UNIT_LOAD,   UNIT_INT,    UNIT_FLT};
			default:
			begin
				pattern  = {UNIT_NONE, UNIT_NONE, UNIT_NONE};
				reserved = 1'b1;
			end
		endcase
	end

	assign unit0 = unit_t'(pattern[8:6]);
	assign unit1 = unit_t'(pattern[5:3]);
	assign unit2 = unit_t'(pattern[2:0]);

endmodule

`default_nettype wire

/* tests/decodeStim.txt */
// B template slot0 slot1 slot2 stallMask(first cycle leftmost) badTemplate
// S unit rfw rd size hasConst constant flags(load store mem memNdx rmw push tlb br jmp jal ret brk rti sync canEx odd)
B 00 0000100C05 40E0000489 FE7FFF0800 00000000 0
S 2 1 05 5 1 0000000000000010 0000000000000000
S 2 1 09 5 0 0000000000106000 0000000000000010
S 2 0 00 5 1 FFFFFFFFFFFFFFFF 0000000000000000
B 03 0000080644 0000030142 0001000141 10100000 0
S 4 1 04 4 1 0000000000000008 1010000000000010
S 2 1 02 5 1 0000000000000003 0000000000000010
S 1 1 01 5 1 0000000000000100 0000000001000000
B 0B 1060000BC6 0000400687 0000000280 00000000 0
S 4 1 06 3 0 0000000000046000 1011000000000010
S 5 1 07 5 1 0000000000000047 0110100000000000
S 1 0 00 5 0 0000000000000000 0000000000010110
B 12 0000000240 FE7FC0073F 000000023E 01100000 0
S 1 0 00 5 0 0000000000000000 0000000000001101
S 1 0 00 5 1 FFFFFFFFFFFFFFFF 0000000000000010
S 1 1 3E 5 0 0000000000000000 0000000000100000
B 14 0001230203 0002800805 28800007C2 00000000 0
S 5 1 03 5 1 0000000000000123 0110010000000000
S 5 0 00 0 1 0000000000000285 0110000000000000
S 5 0 00 4 0 00000000000A0002 0111000000000000
B 15 2040000488 0000000000 3000000081 11000000 0
S 3 1 08 5 0 0000000000084000 0000000000000011
S 3 0 00 5 0 0000000000000000 0000000000000001
S 3 1 01 5 0 00000000000C0000 0000000000000001
B 1E 0000100C05 0000100C05 0000100C05 00000000 1
S 0 0 00 5 0 0000000000000010 0000000000000000
S 0 0 00 5 0 0000000000000010 0000000000000000
S 0 0 00 5 0 0000000000000010 0000000000000000
B 09 0000000644 00000009DF 0000040D10 00100000 0
S 5 1 04 5 0 0000000000000004 0110001000000000
S 5 1 1F 5 0 000000000000001F 0110010000000000
S 1 0 00 5 0 0000000000000004 0000000100000000

/* tests/tbClock.sv */
// ==========================================================
// testbench clock and reset source
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PERIOD = 40
) (
	output logic clk,
	output logic rst
);
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// reset covers the first two rising edges
	initial
	begin
		rst = 1'b1;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* tests/tbDecode.sv */
// ==========================================================
// testbench for the bundle decode stage
// stimulus file reader, bundle driver, slot checks, report
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tbDecode;
	import isaPkg::*;
	import decodePkg::*;

	localparam int MAXB = 16;
	localparam int MASK_W = 8;

	logic       clk;
	logic       rst;
	logic       bundleValid;
	bundle_t    bundleIn;
	logic       stall;
	logic       busy;
	logic       decValid;
	logic [1:0] decSlot;
	decodeBus_t decBus;
	logic       badTemplate;

	bundle_t     bundleA[MAXB];
	logic [7:0]  maskA[MAXB];
	logic        badA[MAXB];
	decodeBus_t  expA[MAXB][3];
	int          numBundles;
	int          passCount;
	int          errCount;
	int          bundleErrs;
	int          cycles;
	int          cycleLimit;

	tbClock #(
		.PERIOD (40)
	) u_tbClock (
		.clk (clk),
		.rst (rst)
	);

	decodeTop #(
		.SLOTS (3)
	) u_decodeTop (
		.clk         (clk),
		.rst         (rst),
		.bundleValid (bundleValid),
		.bundleIn    (bundleIn),
		.stall       (stall),
		.busy        (busy),
		.decValid    (decValid),
		.decSlot     (decSlot),
		.decBus      (decBus),
		.badTemplate (badTemplate)
	);

	// ==========================================================
	// compare tasks
	// ==========================================================
	task automatic checkBus(input string name, input decodeBus_t got, input decodeBus_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errCount++;
			bundleErrs++;
		end
		else
			passCount++;
	endtask

	task automatic checkUnit(input string name, input unit_t got, input unit_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			errCount++;
			bundleErrs++;
		end
		else
			passCount++;
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
			errCount++;
			bundleErrs++;
		end
		else
			passCount++;
	endtask

	task automatic checkSlot(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			errCount++;
			bundleErrs++;
		end
		else
			passCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("at %0t ns: %s", $time, text);
		errCount++;
		bundleErrs++;
	endtask

	// expected bus from the stimulus fields
	function automatic decodeBus_t makeBus(input logic [3:0] u, input logic [3:0] rfw,
		input logic [7:0] rd, input logic [5:0] rs1, input logic [3:0] sz,
		input logic [3:0] hc, input logic [63:0] c, input logic [15:0] fl);
		decodeBus_t b;
		b          = '0;
		b.unit     = unit_t'(u[2:0]);
		b.rfw      = rfw[0];
		b.rd       = rd[5:0];
		b.rs1      = rs1;
		b.hasConst = hc[0];
		b.constant = c;
		b.memSize  = memSize_t'(sz[2:0]);
		b.load     = fl[15];
		b.store    = fl[14];
		b.mem      = fl[13];
		b.memNdx   = fl[12];
		b.rmw      = fl[11];
		b.push     = fl[10];
		b.tlb      = fl[9];
		b.branch   = fl[8];
		b.jump     = fl[7];
		b.jal      = fl[6];
		b.ret      = fl[5];
		b.brk      = fl[4];
		b.rti      = fl[3];
		b.sync     = fl[2];
		b.canEx    = fl[1];
		b.oddball  = fl[0];
		return b;
	endfunction

	task automatic loadStimulus();
		int fd;
		int code;
		int slotIdx;
		string line;
		logic [7:0] t;
		logic [39:0] s0;
		logic [39:0] s1;
		logic [39:0] s2;
		logic [7:0] m;
		logic [3:0] bd;
		logic [3:0] u;
		logic [3:0] rfw;
		logic [7:0] rd;
		logic [3:0] sz;
		logic [3:0] hc;
		logic [63:0] c;
		logic [15:0] fl;
		logic [39:0] word;
		numBundles = 0;
		slotIdx = 0;
		fd = $fopen("tests/decodeStim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file");
			errCount++;
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code == 0)
				continue;
			if (line.len() < 4 || line.substr(0, 1) == "//")
				continue;
			if (line.substr(0, 0) == "B" && numBundles < MAXB)
			begin
				code = $sscanf(line, "B %h %h %h %h %b %h", t, s0, s1, s2, m, bd);
				if (code != 6)
					reportProblem("a bundle line of the stimulus file is malformed");
				bundleA[numBundles] = {s2, s1, s0, t};
				maskA[numBundles] = m;
				badA[numBundles] = bd[0];
				numBundles++;
				slotIdx = 0;
			end
			else if (line.substr(0, 0) == "S" && numBundles > 0 && slotIdx < 3)
			begin
				code = $sscanf(line, "S %h %h %h %h %h %h %b", u, rfw, rd, sz, hc, c, fl);
				if (code != 7)
					reportProblem("a slot line of the stimulus file is malformed");
				word = (slotIdx == 0) ? s0 : (slotIdx == 1) ? s1 : s2;
				// rs1 always sits in bits 15:10 of either format
				expA[numBundles - 1][slotIdx] = makeBus(u, rfw, rd, word[15:10], sz, hc, c, fl);
				slotIdx++;
			end
		end
		$fclose(fd);
	endtask

	// ==========================================================
	// one bundle: accept, step slots under the stall mask, check
	// ==========================================================
	task automatic runBundle(input int idx);
		int k;
		int n;
		logic stallNow;
		logic done;
		bundleErrs = 0;
		@(negedge clk);
		if (decValid)
			reportProblem("decValid was high with no bundle in progress");
		bundleValid = 1'b1;
		bundleIn = bundleA[idx];
		stall = 1'b0;
		@(negedge clk);
		if (!busy)
			reportProblem("the bundle was not accepted");
		// a second bundle while busy must be ignored
		bundleIn = ~bundleA[idx];
		k = 0;
		n = 0;
		stallNow = maskA[idx][MASK_W - 1];
		stall = stallNow;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			bundleValid = 1'b0;
			if (decValid)
			begin
				if (stallNow)
					reportProblem("decValid was high after a stalled edge");
				checkSlot("decSlot", decSlot, 2'(n));
				checkUnit("decBus.unit", decBus.unit, expA[idx][n].unit);
				checkBus("decBus", decBus, expA[idx][n]);
				checkFlag("badTemplate", badTemplate, badA[idx]);
				n++;
			end
			else if (!stallNow)
				reportProblem("no slot came out on an edge without stall");
			else if (n > 0)
				checkBus("decBus", decBus, expA[idx][n - 1]);
			if (!busy)
				done = 1'b1;
			else if (n == 3)
			begin
				reportProblem("busy stayed high after the last slot");
				done = 1'b1;
			end
			k++;
			stallNow = (k < MASK_W) ? maskA[idx][MASK_W - 1 - k] : 1'b0;
			stall = stallNow;
		end
		stall = 1'b0;
		if (n != 3)
			reportProblem("busy fell before all three slots appeared");
		$display("bundle %0d template %0d: %0s", idx, bundleA[idx].template,
			(bundleErrs == 0) ? "ok" : "mismatch");
	endtask

	// run length guard
	initial
	begin
		cycles = 0;
		@(posedge clk);
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("the run did not finish within %0d cycles", cycleLimit);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		bundleValid = 1'b0;
		bundleIn = '0;
		stall = 1'b0;
		passCount = 0;
		errCount = 0;
		cycleLimit = 1000;
		loadStimulus();
		cycleLimit = numBundles * (4 + MASK_W) + 20;
		wait (rst === 1'b0);
		@(negedge clk);
		bundleErrs = 0;
		checkFlag("busy", busy, 1'b0);
		checkFlag("decValid", decValid, 1'b0);
		checkSlot("decSlot", decSlot, 2'd0);
		checkBus("decBus", decBus, '0);
		for (int i = 0; i < numBundles; i++)
			runBundle(i);
		$display("checks passed %0d, errors %0d", passCount, errCount);
		if (errCount == 0 && numBundles > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
